// File: Makefile
# Verilator build and run for the LC4 pipeline testbench

VERILATOR ?= verilator
TOP       ?= lc4_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: design/lc4_cfg.svh
`ifndef LC4_CFG_SVH
`define LC4_CFG_SVH

// First fetch address after reset
`define LC4_RESET_PC 16'h8200

// Data, address and register width
`define LC4_WORD_W 16

// General purpose registers R0..R7
`define LC4_NREGS 8

`endif

// File: design/lc4_core.sv
`timescale 1ns/1ps
`include "lc4_cfg.svh"

module lc4_core (
  input  logic                   gwe,
  input  logic                   i_reset,
  output logic [`LC4_WORD_W-1:0] o_imem_addr,
  input  logic [`LC4_WORD_W-1:0] i_imem_data,
  output lc4_pkg::dmem_req_t     o_dmem,
  input  logic [`LC4_WORD_W-1:0] i_dmem_rdata,
  output lc4_pkg::trace_t        o_trace
);

  logic [`LC4_WORD_W-1:0] pc_q;
  logic [`LC4_WORD_W-1:0] pc_next;
  logic                   fd_valid;
  logic [`LC4_WORD_W-1:0] fd_pc;
  logic [`LC4_WORD_W-1:0] fd_insn;

  lc4_pkg::ctrl_t         d_ctrl;
  logic [`LC4_WORD_W-1:0] d_imm;
  logic [`LC4_WORD_W-1:0] d_rs_data;
  logic [`LC4_WORD_W-1:0] d_rt_data;
  logic [2:0]             rf_nzp;
  logic                   ld_stall;

  lc4_pkg::dx_t           dx_d, dx_q;
  lc4_pkg::xm_t           xm_d, xm_q, m_fwd;
  lc4_pkg::mw_t           mw_d, mw_q;

  logic [`LC4_WORD_W-1:0] x_result;
  logic [2:0]             x_nzp;
  logic [`LC4_WORD_W-1:0] x_store_data;
  logic                   x_redirect;
  logic [`LC4_WORD_W-1:0] x_target;

  logic                   w_we;
  logic [2:0]             w_nzp;

  // Fetch
  assign o_imem_addr = pc_q;
  assign pc_next = x_redirect ? x_target : (ld_stall ? pc_q : pc_q + 16'd1);

  always_ff @(posedge gwe) begin
    if (i_reset) begin
      pc_q     <= `LC4_RESET_PC;
      fd_valid <= 1'b0;
    end else begin
      pc_q <= pc_next;
      if (x_redirect) begin
        fd_valid <= 1'b0;                    // Wrong-path fetch
      end else if (!ld_stall) begin
        fd_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge gwe) begin
    if (!ld_stall) begin                     // Hold the decode entry on a stall
      fd_pc   <= pc_q;
      fd_insn <= i_imem_data;
    end
  end

  // Decode
  lc4_decoder u_decoder (
    .i_insn (fd_insn),
    .o_ctrl (d_ctrl),
    .o_imm  (d_imm)
  );

  lc4_regfile u_regfile (
    .gwe       (gwe),
    .i_reset   (i_reset),
    .i_rs_sel  (d_ctrl.rs),
    .i_rt_sel  (d_ctrl.rt),
    .o_rs_data (d_rs_data),
    .o_rt_data (d_rt_data),
    .i_wsel    (mw_q.ctrl.rd),
    .i_wdata   (mw_q.result),
    .i_we      (w_we),
    .i_nzp     (w_nzp),
    .i_nzp_we  (w_we),                       // Every register write also sets NZP
    .o_nzp     (rf_nzp)
  );

  // Load in execute feeding the instruction in decode
  assign ld_stall = fd_valid && dx_q.valid && dx_q.ctrl.is_load &&
                    ((d_ctrl.rs_re && d_ctrl.rs == dx_q.ctrl.rd) ||
                     (d_ctrl.rt_re && d_ctrl.rt == dx_q.ctrl.rd));

  always_comb begin
    dx_d.valid   = fd_valid && !x_redirect && !ld_stall;   // Bubble on flush or stall
    dx_d.pc      = fd_pc;
    dx_d.insn    = fd_insn;
    dx_d.ctrl    = d_ctrl;
    dx_d.imm     = d_imm;
    dx_d.rs_data = d_rs_data;
    dx_d.rt_data = d_rt_data;
  end

  // Execute
  lc4_execute u_execute (
    .i_dx         (dx_q),
    .i_xm         (m_fwd),
    .i_mw_wsel    (mw_q.ctrl.rd),
    .i_mw_we      (w_we),
    .i_mw_result  (mw_q.result),
    .i_mw_nzp     (w_nzp),
    .i_nzp        (rf_nzp),
    .o_result     (x_result),
    .o_nzp        (x_nzp),
    .o_store_data (x_store_data),
    .o_redirect   (x_redirect),
    .o_target     (x_target)
  );

  always_comb begin
    xm_d.valid      = dx_q.valid;
    xm_d.pc         = dx_q.pc;
    xm_d.insn       = dx_q.insn;
    xm_d.ctrl       = dx_q.ctrl;
    xm_d.result     = x_result;
    xm_d.nzp        = x_nzp;
    xm_d.store_data = x_store_data;
  end

  // Memory, same-cycle data port
  assign o_dmem.we    = xm_q.valid && xm_q.ctrl.is_store;
  assign o_dmem.addr  = xm_q.result;
  assign o_dmem.wdata = xm_q.store_data;

  // Load data replaces the address for bypass and branch flags
  always_comb begin
    m_fwd = xm_q;
    if (xm_q.ctrl.is_load) begin
      m_fwd.result = i_dmem_rdata;
      m_fwd.nzp    = lc4_pkg::nzp_of(i_dmem_rdata);
    end
  end

  always_comb begin
    mw_d.valid  = xm_q.valid;
    mw_d.pc     = xm_q.pc;
    mw_d.insn   = xm_q.insn;
    mw_d.ctrl   = xm_q.ctrl;
    mw_d.result = m_fwd.result;
    mw_d.nzp    = xm_q.nzp;
  end

  // Stage registers, only valid bits see reset
  always_ff @(posedge gwe) begin
    if (i_reset) begin
      dx_q.valid <= 1'b0;
      xm_q.valid <= 1'b0;
      mw_q.valid <= 1'b0;
    end else begin
      dx_q <= dx_d;
      xm_q <= xm_d;
      mw_q <= mw_d;
    end
  end

  // Writeback
  assign w_we  = mw_q.valid && mw_q.ctrl.rf_we;
  assign w_nzp = mw_q.ctrl.is_load ? lc4_pkg::nzp_of(mw_q.result) : mw_q.nzp;

  always_comb begin
    o_trace.valid  = mw_q.valid;
    o_trace.pc     = mw_q.pc;
    o_trace.insn   = mw_q.insn;
    o_trace.rf_we  = w_we;
    o_trace.wsel   = mw_q.ctrl.rd;
    o_trace.wdata  = mw_q.result;
    o_trace.nzp_we = w_we;
    o_trace.nzp    = w_nzp;
  end

endmodule

// File: design/lc4_decoder.sv
`timescale 1ns/1ps

module lc4_decoder (
  input  logic [15:0]    i_insn,
  output lc4_pkg::ctrl_t o_ctrl,
  output logic [15:0]    o_imm
);

  always_comb begin
    o_ctrl        = '0;            // No-op unless an opcode below matches
    o_ctrl.alu_op = lc4_pkg::ALU_ADD;
    o_ctrl.rd     = i_insn[11:9];
    o_ctrl.rs     = i_insn[8:6];
    o_ctrl.rt     = i_insn[2:0];
    o_imm         = '0;
    case (lc4_pkg::opcode_e'(i_insn[15:12]))
      lc4_pkg::OP_BR: begin
        o_ctrl.is_branch = 1'b1;
        o_ctrl.br_nzp    = i_insn[11:9];              // NZP mask
        o_imm            = {{7{i_insn[8]}}, i_insn[8:0]};
      end
      lc4_pkg::OP_ARITH: begin
        if (i_insn[5]) begin                          // ADD imm5
          o_ctrl.rs_re = 1'b1;
          o_ctrl.rf_we = 1'b1;
          o_imm        = {{11{i_insn[4]}}, i_insn[4:0]};
        end else if (i_insn[5:3] == 3'b000 || i_insn[5:3] == 3'b010) begin
          o_ctrl.rs_re  = 1'b1;
          o_ctrl.rt_re  = 1'b1;
          o_ctrl.rf_we  = 1'b1;
          o_ctrl.alu_op = i_insn[4] ? lc4_pkg::ALU_SUB : lc4_pkg::ALU_ADD;
        end
        // MUL and DIV fall through as no-ops
      end
      lc4_pkg::OP_LOGIC: begin
        if (i_insn[5]) begin                          // AND imm5
          o_ctrl.rs_re  = 1'b1;
          o_ctrl.rf_we  = 1'b1;
          o_ctrl.alu_op = lc4_pkg::ALU_AND;
          o_imm         = {{11{i_insn[4]}}, i_insn[4:0]};
        end else if (i_insn[5:3] == 3'b000) begin
          o_ctrl.rs_re  = 1'b1;
          o_ctrl.rt_re  = 1'b1;
          o_ctrl.rf_we  = 1'b1;
          o_ctrl.alu_op = lc4_pkg::ALU_AND;
        end
      end
      lc4_pkg::OP_LDR: begin
        o_ctrl.rs_re   = 1'b1;                        // Base register
        o_ctrl.rf_we   = 1'b1;
        o_ctrl.is_load = 1'b1;
        o_ctrl.alu_op  = lc4_pkg::ALU_ADDR;
        o_imm          = {{10{i_insn[5]}}, i_insn[5:0]};
      end
      lc4_pkg::OP_STR: begin
        o_ctrl.rs_re    = 1'b1;
        o_ctrl.rt_re    = 1'b1;
        o_ctrl.rt       = i_insn[11:9];               // Store data sits in the rd field
        o_ctrl.is_store = 1'b1;
        o_ctrl.alu_op   = lc4_pkg::ALU_ADDR;
        o_imm           = {{10{i_insn[5]}}, i_insn[5:0]};
      end
      lc4_pkg::OP_CONST: begin
        o_ctrl.rf_we  = 1'b1;
        o_ctrl.alu_op = lc4_pkg::ALU_PASS_IMM;
        o_imm         = {{7{i_insn[8]}}, i_insn[8:0]};
      end
      lc4_pkg::OP_JMP: begin
        if (i_insn[11]) begin                         // JMPR not supported
          o_ctrl.is_jump = 1'b1;
          o_imm          = {{5{i_insn[10]}}, i_insn[10:0]};
        end
      end
      default: ;
    endcase
  end

endmodule

// File: design/lc4_execute.sv
`timescale 1ns/1ps
`include "lc4_cfg.svh"

module lc4_execute (
  input  lc4_pkg::dx_t           i_dx,
  input  lc4_pkg::xm_t           i_xm,        // Memory stage, load data already merged
  input  logic [2:0]             i_mw_wsel,
  input  logic                   i_mw_we,
  input  logic [`LC4_WORD_W-1:0] i_mw_result,
  input  logic [2:0]             i_mw_nzp,
  input  logic [2:0]             i_nzp,       // Committed NZP register
  output logic [`LC4_WORD_W-1:0] o_result,
  output logic [2:0]             o_nzp,
  output logic [`LC4_WORD_W-1:0] o_store_data,
  output logic                   o_redirect,
  output logic [`LC4_WORD_W-1:0] o_target
);

  logic                   m_we;
  logic [`LC4_WORD_W-1:0] a_op;
  logic [`LC4_WORD_W-1:0] rt_val;
  logic [`LC4_WORD_W-1:0] b_op;
  logic [2:0]             br_src;
  logic                   taken;

  // Youngest producer wins
  function automatic logic [`LC4_WORD_W-1:0] pick(input logic [2:0] sel,
                                                  input logic [`LC4_WORD_W-1:0] rdata);
    if (m_we && i_xm.ctrl.rd == sel) begin
      pick = i_xm.result;
    end else if (i_mw_we && i_mw_wsel == sel) begin
      pick = i_mw_result;
    end else begin
      pick = rdata;
    end
  endfunction

  assign m_we   = i_xm.valid && i_xm.ctrl.rf_we;

  always_comb begin
    a_op   = pick(i_dx.ctrl.rs, i_dx.rs_data);
    rt_val = pick(i_dx.ctrl.rt, i_dx.rt_data);
  end

  assign b_op   = i_dx.ctrl.rt_re ? rt_val : i_dx.imm;   // Immediate forms

  always_comb begin
    case (i_dx.ctrl.alu_op)
      lc4_pkg::ALU_SUB:      o_result = a_op - b_op;
      lc4_pkg::ALU_AND:      o_result = a_op & b_op;
      lc4_pkg::ALU_PASS_IMM: o_result = i_dx.imm;
      lc4_pkg::ALU_ADDR:     o_result = a_op + i_dx.imm;   // STR keeps rt for data
      default:               o_result = a_op + b_op;
    endcase
  end

  assign o_nzp        = lc4_pkg::nzp_of(o_result);
  assign o_store_data = rt_val;                            // Bypassed store data

  // Flags of the youngest NZP writer still in flight
  always_comb begin
    if (m_we) begin
      br_src = i_xm.nzp;
    end else if (i_mw_we) begin
      br_src = i_mw_nzp;
    end else begin
      br_src = i_nzp;
    end
  end

  assign taken      = |(i_dx.ctrl.br_nzp & br_src);
  assign o_redirect = i_dx.valid && ((i_dx.ctrl.is_branch && taken) || i_dx.ctrl.is_jump);
  assign o_target   = i_dx.pc + 16'd1 + i_dx.imm;          // BR and JMP share PC+1+offset

endmodule

// File: design/lc4_pkg.sv
package lc4_pkg;

  // Top four instruction bits, subset only
  typedef enum logic [3:0] {
    OP_BR    = 4'h0,
    OP_ARITH = 4'h1,
    OP_LOGIC = 4'h5,
    OP_LDR   = 4'h6,
    OP_STR   = 4'h7,
    OP_CONST = 4'h9,
    OP_JMP   = 4'hc
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,      // rs + (rt or imm)
    ALU_SUB,
    ALU_AND,
    ALU_PASS_IMM, // CONST
    ALU_ADDR      // rs + imm, memory address
  } alu_op_e;

  typedef struct packed {
    logic [2:0] rd;
    logic [2:0] rs;
    logic [2:0] rt;
    logic       rs_re;
    logic       rt_re;     // Low on immediate forms, selects imm as operand b
    logic       rf_we;     // Also the NZP write enable in this subset
    logic       is_load;
    logic       is_store;
    logic       is_branch;
    logic       is_jump;
    alu_op_e    alu_op;
    logic [2:0] br_nzp;
  } ctrl_t;

  typedef struct packed {
    logic        valid;
    logic [15:0] pc;
    logic [15:0] insn;
    ctrl_t       ctrl;
    logic [15:0] imm;
    logic [15:0] rs_data;
    logic [15:0] rt_data;
  } dx_t;

  typedef struct packed {
    logic        valid;
    logic [15:0] pc;
    logic [15:0] insn;
    ctrl_t       ctrl;
    logic [15:0] result;     // ALU value or memory address
    logic [2:0]  nzp;
    logic [15:0] store_data;
  } xm_t;

  typedef struct packed {
    logic        valid;
    logic [15:0] pc;
    logic [15:0] insn;
    ctrl_t       ctrl;
    logic [15:0] result;     // Load data already selected
    logic [2:0]  nzp;        // Stale for loads
  } mw_t;

  typedef struct packed {
    logic        we;
    logic [15:0] addr;
    logic [15:0] wdata;
  } dmem_req_t;

  typedef struct packed {
    logic        valid;
    logic [15:0] pc;
    logic [15:0] insn;
    logic        rf_we;
    logic [2:0]  wsel;
    logic [15:0] wdata;
    logic        nzp_we;
    logic [2:0]  nzp;
  } trace_t;

  // Sign of a 16-bit value as N, Z, P
  function automatic logic [2:0] nzp_of(input logic [15:0] value);
    nzp_of = {value[15], value == 16'h0000, !value[15] && (value != 16'h0000)};
  endfunction

endpackage

// File: design/lc4_regfile.sv
`timescale 1ns/1ps
`include "lc4_cfg.svh"

module lc4_regfile (
  input  logic                   gwe,
  input  logic                   i_reset,
  input  logic [2:0]             i_rs_sel,
  input  logic [2:0]             i_rt_sel,
  output logic [`LC4_WORD_W-1:0] o_rs_data,
  output logic [`LC4_WORD_W-1:0] o_rt_data,
  input  logic [2:0]             i_wsel,
  input  logic [`LC4_WORD_W-1:0] i_wdata,
  input  logic                   i_we,
  input  logic [2:0]             i_nzp,
  input  logic                   i_nzp_we,
  output logic [2:0]             o_nzp
);

  logic [`LC4_WORD_W-1:0] regs [`LC4_NREGS];
  logic [2:0]             nzp_q;

  always_ff @(posedge gwe) begin
    if (i_we) regs[i_wsel] <= i_wdata;
  end

  always_ff @(posedge gwe) begin
    if (i_reset) begin
      nzp_q <= 3'b000;
    end else if (i_nzp_we) begin
      nzp_q <= i_nzp;
    end
  end

  // Writeback value shows up in decode the same cycle
  assign o_rs_data = (i_we && i_wsel == i_rs_sel) ? i_wdata : regs[i_rs_sel];
  assign o_rt_data = (i_we && i_wsel == i_rt_sel) ? i_wdata : regs[i_rt_sel];
  assign o_nzp     = nzp_q;

endmodule

// File: filelist.f
+incdir+design
design/lc4_pkg.sv
design/lc4_decoder.sv
design/lc4_regfile.sv
design/lc4_execute.sv
design/lc4_core.sv
testbench/lc4_clkgen.sv
testbench/lc4_asserts.sv
testbench/lc4_tb.sv

// File: testbench/lc4_asserts.sv
`timescale 1ns/1ps

module lc4_asserts (
  input logic               gwe,
  input logic               i_reset,
  input lc4_pkg::dmem_req_t i_dmem,
  input lc4_pkg::trace_t    i_trace
);

  // From the second reset edge on the valid bits are clear
  a_reset_quiet: assert property (@(posedge gwe)
    i_reset && $past(i_reset) |-> !i_dmem.we && !i_trace.valid)
    else $error("Store or retirement while reset is held");

  // A register write only comes from a real instruction
  a_we_valid: assert property (@(posedge gwe) disable iff (i_reset)
    i_trace.rf_we |-> i_trace.valid)
    else $error("Trace rf_we without valid");

  // N, Z and P are exclusive
  a_nzp_onehot: assert property (@(posedge gwe) disable iff (i_reset)
    i_trace.nzp_we |-> $onehot(i_trace.nzp))
    else $error("Trace NZP not one-hot: %b", i_trace.nzp);

endmodule

bind lc4_core lc4_asserts u_asserts (
  .gwe     (gwe),
  .i_reset (i_reset),
  .i_dmem  (o_dmem),
  .i_trace (o_trace)
);

// File: testbench/lc4_clkgen.sv
`timescale 1ns/1ps

module lc4_clkgen (
  input  logic i_rst_req,  // Restarts the reset sequence, sampled at the rising edge
  output logic o_gwe,
  output logic o_reset
);

  int unsigned rst_cnt;    // Rising edges still to see reset high
  logic        req;

  initial begin
    o_gwe = 1'b0;
    forever #10 o_gwe = ~o_gwe;  // 20 ns period
  end

  initial begin
    o_reset = 1'b1;
    rst_cnt = 16;
    forever begin
      @(posedge o_gwe);
      req = i_rst_req;
      #2;                        // Same drive delay as the testbench
      if (req) begin
        rst_cnt = 16;
      end else if (rst_cnt != 0) begin
        rst_cnt = rst_cnt - 1;
      end
      o_reset = (rst_cnt != 0);
    end
  end

endmodule

// File: testbench/lc4_tb.sv
`timescale 1ns/1ps
`include "lc4_cfg.svh"

module lc4_tb;

  localparam logic [15:0] pc0 = `LC4_RESET_PC;

  logic               gwe;
  logic               rst;
  logic               rst_req;
  logic [15:0]        imem_addr;
  logic [15:0]        imem_off;
  logic [15:0]        imem_data;
  lc4_pkg::dmem_req_t dmem_req;
  logic [15:0]        dmem_rdata;
  lc4_pkg::trace_t    trace;

  logic [15:0]        imem [64];    // Word 0 sits at the reset PC
  logic [15:0]        dmem [256];
  lc4_pkg::trace_t    trace_q [$];  // Retired records of the running test
  int                 errors;
  int                 checks;
  int                 timeouts;
  integer             seed;

  lc4_clkgen u_clkgen (
    .i_rst_req (rst_req),
    .o_gwe     (gwe),
    .o_reset   (rst)
  );

  lc4_core u_lc4_core (
    .gwe          (gwe),
    .i_reset      (rst),
    .o_imem_addr  (imem_addr),
    .i_imem_data  (imem_data),
    .o_dmem       (dmem_req),
    .i_dmem_rdata (dmem_rdata),
    .o_trace      (trace)
  );

  // Both memories answer in the same cycle
  assign imem_off   = imem_addr - pc0;
  assign imem_data  = (imem_off < 16'd64) ? imem[imem_off[5:0]] : 16'h0000;  // NOP outside
  assign dmem_rdata = dmem[dmem_req.addr[7:0]];

  initial begin
    for (int i = 0; i < 256; i++) begin
      dmem[i] <= {8'(i), 8'(~i)};  // Every word differs
    end
    forever begin
      @(posedge gwe);
      if (dmem_req.we) dmem[dmem_req.addr[7:0]] <= dmem_req.wdata;
    end
  end

  function automatic logic [15:0] sext9(input logic [8:0] v);
    sext9 = {{7{v[8]}}, v};
  endfunction

  function automatic logic [15:0] sext5(input logic [4:0] v);
    sext5 = {{11{v[4]}}, v};
  endfunction

  function automatic logic [2:0] flags_of(input logic [15:0] v);
    if ($signed(v) < 0) flags_of = 3'b100;
    else if (v == 16'h0000) flags_of = 3'b010;
    else flags_of = 3'b001;
  endfunction

  function automatic logic [15:0] const_word(input logic [2:0] rd, input logic [8:0] imm);
    const_word = {4'h9, rd, imm};
  endfunction

  // ADD, SUB with op 1 and AND with op 5
  function automatic logic [15:0] reg_word(input logic [3:0] op, input logic [2:0] rd,
                                           input logic [2:0] rs, input logic [2:0] sub,
                                           input logic [2:0] rt);
    reg_word = {op, rd, rs, sub, rt};
  endfunction

  function automatic logic [15:0] imm_word(input logic [3:0] op, input logic [2:0] rd,
                                           input logic [2:0] rs, input logic [4:0] imm);
    imm_word = {op, rd, rs, 1'b1, imm};
  endfunction

  // LDR is op 6, STR op 7 with the data register in the rd field
  function automatic logic [15:0] mem_word(input logic [3:0] op, input logic [2:0] rd,
                                           input logic [2:0] rs, input logic [5:0] imm);
    mem_word = {op, rd, rs, imm};
  endfunction

  function automatic logic [15:0] br_word(input logic [2:0] nzp, input logic [8:0] imm);
    br_word = {4'h0, nzp, imm};
  endfunction

  function automatic logic [15:0] jmp_word(input logic [10:0] imm);
    jmp_word = {4'hc, 1'b1, imm};
  endfunction

  task automatic clear_imem();
    for (int i = 0; i < 64; i++) begin
      imem[i] = 16'h0000;
    end
  endtask

  task automatic reset_dut();
    int n;
    @(posedge gwe);
    #2;
    rst_req = 1'b1;
    @(posedge gwe);                // Clock generator takes the request here
    #2;
    rst_req = 1'b0;
    @(posedge gwe);                // First edge that applies reset
    n = 0;
    @(negedge gwe);
    while (rst && n < 40) begin
      checks++;
      if (trace.valid || dmem_req.we) begin
        $display("[FAIL] trace.valid %h dmem.we %h during reset", trace.valid, dmem_req.we);
        errors++;
      end
      @(negedge gwe);
      n++;
    end
    if (rst) begin
      $display("Timeout: reset still asserted after %0d cycles", n);
      errors++;
      timeouts++;
    end
  endtask

  task automatic collect_trace(input int n);
    int cycles;
    trace_q.delete();
    cycles = 0;
    while (trace_q.size() < n && cycles < 200) begin
      @(negedge gwe);              // Writeback register settled
      if (trace.valid) trace_q.push_back(trace);
      cycles++;
    end
    if (trace_q.size() < n) begin
      $display("Timeout: only %0d of %0d instructions retired", trace_q.size(), n);
      errors++;
      timeouts++;
    end
  endtask

  task automatic check_rec(input int idx, input logic [15:0] exp_pc, input logic exp_we,
                           input logic [2:0] exp_wsel, input logic [15:0] exp_wdata);
    lc4_pkg::trace_t t;
    logic [15:0]     off;
    logic [15:0]     exp_insn;
    if (idx >= trace_q.size()) return;   // Record never retired
    t = trace_q[idx];
    off = exp_pc - pc0;
    exp_insn = (off < 16'd64) ? imem[off[5:0]] : 16'h0000;  // Program word at that PC
    checks++;
    if (t.pc !== exp_pc) begin
      $display("[FAIL] trace.pc rec %0d: got %h, expected %h", idx, t.pc, exp_pc);
      errors++;
    end
    if (t.insn !== exp_insn) begin
      $display("[FAIL] trace.insn rec %0d: got %h, expected %h", idx, t.insn, exp_insn);
      errors++;
    end
    if (t.rf_we !== exp_we) begin
      $display("[FAIL] trace.rf_we rec %0d: got %h, expected %h", idx, t.rf_we, exp_we);
      errors++;
    end
    if (t.nzp_we !== exp_we) begin       // Every register write sets NZP
      $display("[FAIL] trace.nzp_we rec %0d: got %h, expected %h", idx, t.nzp_we, exp_we);
      errors++;
    end
    if (exp_we) begin
      if (t.wsel !== exp_wsel) begin
        $display("[FAIL] trace.wsel rec %0d: got %h, expected %h", idx, t.wsel, exp_wsel);
        errors++;
      end
      if (t.wdata !== exp_wdata) begin
        $display("[FAIL] trace.wdata rec %0d: got %h, expected %h", idx, t.wdata, exp_wdata);
        errors++;
      end
      if (t.nzp !== flags_of(exp_wdata)) begin
        $display("[FAIL] trace.nzp rec %0d: got %h, expected %h", idx, t.nzp,
                 flags_of(exp_wdata));
        errors++;
      end
    end
  endtask

  task automatic test_reset();
    clear_imem();
    imem[0] = const_word(3'd1, 9'h0ab);
    imem[1] = const_word(3'd2, 9'h1ff);  // -1
    reset_dut();
    collect_trace(2);
    check_rec(0, pc0, 1'b1, 3'd1, 16'h00ab);
    check_rec(1, pc0 + 16'd1, 1'b1, 3'd2, 16'hffff);
  endtask

  task automatic test_arith();
    logic [31:0] rnd;
    logic [8:0]  c1;
    logic [8:0]  c2;
    logic [4:0]  i1;
    logic [4:0]  i2;
    logic [15:0] v [9];
    logic [2:0]  dst [9];
    dst = '{3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd6, 3'd7, 3'd1, 3'd2};
    for (int it = 0; it < 4; it++) begin
      rnd = $random(seed);
      c1  = rnd[8:0];
      c2  = rnd[17:9];
      i1  = rnd[22:18];
      i2  = rnd[27:23];
      clear_imem();
      imem[0] = const_word(3'd1, c1);
      imem[1] = const_word(3'd2, c2);
      imem[2] = reg_word(4'h1, 3'd3, 3'd1, 3'b000, 3'd2);  // ADD r3, r1, r2
      imem[3] = reg_word(4'h1, 3'd4, 3'd3, 3'b010, 3'd1);  // SUB r4, r3, r1
      imem[4] = reg_word(4'h5, 3'd5, 3'd4, 3'b000, 3'd3);  // AND r5, r4, r3
      imem[5] = imm_word(4'h1, 3'd6, 3'd5, i1);
      imem[6] = imm_word(4'h5, 3'd7, 3'd6, i2);
      imem[7] = reg_word(4'h1, 3'd1, 3'd7, 3'b000, 3'd6);
      imem[8] = reg_word(4'h1, 3'd2, 3'd1, 3'b010, 3'd7);
      v[0] = sext9(c1);
      v[1] = sext9(c2);
      v[2] = v[0] + v[1];
      v[3] = v[2] - v[0];
      v[4] = v[3] & v[2];
      v[5] = v[4] + sext5(i1);
      v[6] = v[5] & sext5(i2);
      v[7] = v[6] + v[5];
      v[8] = v[7] - v[6];
      reset_dut();
      collect_trace(9);
      for (int k = 0; k < 9; k++) begin
        check_rec(k, pc0 + 16'(k), 1'b1, dst[k], v[k]);
      end
    end
  endtask

  task automatic test_store_load();
    logic [31:0] rnd;
    logic [8:0]  base;
    logic [8:0]  c2;
    logic [15:0] val;
    logic [7:0]  addr;
    for (int it = 0; it < 3; it++) begin
      rnd  = $random(seed);
      base = {2'b00, rnd[6:0]};        // Small and positive
      c2   = rnd[16:8];
      val  = sext9(c2);
      addr = base[7:0] + 8'd5;
      clear_imem();
      imem[0] = const_word(3'd1, base);
      imem[1] = const_word(3'd2, c2);
      imem[2] = mem_word(4'h7, 3'd2, 3'd1, 6'd5);          // STR r2, r1, #5
      imem[3] = mem_word(4'h6, 3'd3, 3'd1, 6'd5);          // LDR r3, r1, #5
      imem[4] = reg_word(4'h1, 3'd4, 3'd3, 3'b000, 3'd2);  // Uses the load
      reset_dut();
      collect_trace(5);
      check_rec(0, pc0, 1'b1, 3'd1, {7'd0, base});
      check_rec(1, pc0 + 16'd1, 1'b1, 3'd2, val);
      check_rec(2, pc0 + 16'd2, 1'b0, 3'd0, 16'h0000);
      check_rec(3, pc0 + 16'd3, 1'b1, 3'd3, val);
      check_rec(4, pc0 + 16'd4, 1'b1, 3'd4, val + val);
      checks++;
      if (dmem[addr] !== val) begin
        $display("[FAIL] dmem[%h]: got %h, expected %h", addr, dmem[addr], val);
        errors++;
      end
    end
  endtask

  task automatic test_branches();
    logic [8:0] vals [3];
    logic       taken;
    vals = '{9'h1f0, 9'h000, 9'h023};  // Negative, zero, positive
    for (int m = 1; m < 8; m++) begin
      for (int s = 0; s < 3; s++) begin
        taken = |(3'(m) & flags_of(sext9(vals[s])));
        clear_imem();
        imem[0] = const_word(3'd1, vals[s]);
        imem[1] = br_word(3'(m), 9'd2);   // Target PC+1+2, word 4
        imem[2] = const_word(3'd2, 9'd1);
        imem[3] = const_word(3'd3, 9'd2);
        imem[4] = const_word(3'd4, 9'd3);
        reset_dut();
        collect_trace(4);
        check_rec(0, pc0, 1'b1, 3'd1, sext9(vals[s]));
        check_rec(1, pc0 + 16'd1, 1'b0, 3'd0, 16'h0000);
        if (taken) begin
          check_rec(2, pc0 + 16'd4, 1'b1, 3'd4, 16'h0003);
          check_rec(3, pc0 + 16'd5, 1'b0, 3'd0, 16'h0000);  // NOP past the program
        end else begin
          check_rec(2, pc0 + 16'd2, 1'b1, 3'd2, 16'h0001);
          check_rec(3, pc0 + 16'd3, 1'b1, 3'd3, 16'h0002);
        end
      end
    end
  endtask

  task automatic test_jump_loop();
    logic [15:0] pcs [9];
    logic [15:0] r1;
    pcs = '{16'd0, 16'd1, 16'd5, 16'd6, 16'd1, 16'd5, 16'd6, 16'd1, 16'd5};
    clear_imem();
    imem[0] = const_word(3'd1, 9'd5);
    imem[1] = jmp_word(11'd3);                    // Over the fillers to word 5
    imem[2] = imm_word(4'h1, 3'd1, 3'd1, 5'd1);   // Fillers never retire
    imem[3] = imm_word(4'h1, 3'd1, 3'd1, 5'd1);
    imem[4] = imm_word(4'h1, 3'd1, 3'd1, 5'd1);
    imem[5] = imm_word(4'h1, 3'd1, 3'd1, 5'd2);
    imem[6] = jmp_word(11'h7fa);                  // -6, back to word 1
    reset_dut();
    collect_trace(9);
    r1 = 16'd5;
    for (int k = 0; k < 9; k++) begin
      if (pcs[k] == 16'd5) r1 = r1 + 16'd2;
      check_rec(k, pc0 + pcs[k], k == 0 || pcs[k] == 16'd5, 3'd1, r1);
    end
  endtask

  initial begin
    seed     = 32'h4bfb74cc;
    errors   = 0;
    checks   = 0;
    timeouts = 0;
    rst_req  = 1'b0;
    clear_imem();
    test_reset();
    test_arith();
    test_store_load();
    test_branches();
    test_jump_loop();
    $display("Checks: %0d  errors: %0d  timeouts: %0d", checks, errors, timeouts);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule
